/* file_loader.sv */
////////////////////
// file channel: download writes to the core, upload reads from it
////////////////////
`timescale 1ns/1ns
`include "hps_defs.svh"

module file_loader (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   io_strobe,
	input  logic                   fp_enable,
	input  logic [`HPS_WORD_W-1:0] io_din,
	output logic [`HPS_WORD_W-1:0] fp_dout,
	output logic                   ioctl_download,
	output logic                   ioctl_upload,
	output logic                   ioctl_wr,
	output logic                   ioctl_rd,
	output logic [`HPS_WORD_W-1:0] ioctl_index,
	output logic [`HPS_ADDR_W-1:0] ioctl_addr,
	output logic [`HPS_DATA_W-1:0] ioctl_dout,
	input  logic [`HPS_DATA_W-1:0] ioctl_din
);

	hps_file_pkg::fio_cmd_e cmd;
	hps_file_pkg::xfer_mode_e mode;
	logic [`HPS_CNT_W-1:0] cnt;
	// next download address
	logic [`HPS_ADDR_W-1:0] addr;
	logic wr;

	assign ioctl_download = mode == hps_file_pkg::xfer_download;
	assign ioctl_upload = mode == hps_file_pkg::xfer_upload;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mode <= hps_file_pkg::xfer_idle;
			cnt <= '0;
			wr <= 1'b0;
			ioctl_wr <= 1'b0;
			ioctl_rd <= 1'b0;
			fp_dout <= '0;
		end else begin
			// write strobe trails the address and data by one cycle
			ioctl_wr <= wr;
			wr <= 1'b0;
			ioctl_rd <= 1'b0;
			if (!fp_enable) begin
				cnt <= '0;
			end else if (io_strobe) begin
				if (cnt != {`HPS_CNT_W{1'b1}})
					cnt <= cnt + 1'b1;
				if (cnt == 0) begin
					cmd <= hps_file_pkg::fio_cmd_e'(io_din[7:0]);
				end else begin
					case (cmd)
						hps_file_pkg::file_index: ioctl_index <= io_din;
						hps_file_pkg::file_tx: begin
							if (cnt == 1) begin
								if (io_din[7:0] == `HPS_UPLOAD_MARK) begin
									mode <= hps_file_pkg::xfer_upload;
									ioctl_addr <= '0;
									ioctl_rd <= 1'b1;
								end else if (io_din[7:0] != 8'h00) begin
									mode <= hps_file_pkg::xfer_download;
									addr <= '0;
								end else begin
									// end of transfer, show the final length
									if (mode == hps_file_pkg::xfer_download)
										ioctl_addr <= addr;
									mode <= hps_file_pkg::xfer_idle;
								end
							end else if (cnt == 2) begin
								ioctl_addr[`HPS_WORD_W-1:0] <= io_din;
								addr[`HPS_WORD_W-1:0] <= io_din;
							end else if (cnt == 3) begin
								ioctl_addr[`HPS_ADDR_W-1:`HPS_WORD_W] <=
									io_din[`HPS_ADDR_W-`HPS_WORD_W-1:0];
								addr[`HPS_ADDR_W-1:`HPS_WORD_W] <=
									io_din[`HPS_ADDR_W-`HPS_WORD_W-1:0];
							end
						end
						hps_file_pkg::file_tx_dat: begin
							if (mode == hps_file_pkg::xfer_download) begin
								ioctl_addr <= addr;
								ioctl_dout <= io_din[`HPS_DATA_W-1:0];
								wr <= 1'b1;
								addr <= addr + 1'b1;
							end else if (mode == hps_file_pkg::xfer_upload) begin
								ioctl_addr <= ioctl_addr + 1'b1;
								fp_dout <= {{(`HPS_WORD_W-`HPS_DATA_W){1'b0}}, ioctl_din};
								ioctl_rd <= 1'b1;
							end
						end
						default: ;
					endcase
				end
			end
		end
	end

	// write pulses belong to a download, read pulses to an upload
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> ioctl_download);

	a_rd_in_upload: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_rd |-> ioctl_upload);

endmodule

/* hps_cmd_decoder.sv */
////////////////////
// user command channel: config, joystick and status registers,
// status-set request and config string readback
////////////////////
`timescale 1ns/1ns
`include "hps_defs.svh"

module hps_cmd_decoder #(
	parameter conf_str = "CORE;"
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     io_strobe,
	input  logic                     io_enable,
	input  logic [`HPS_WORD_W-1:0]   io_din,
	output logic [`HPS_WORD_W-1:0]   uio_dout,
	output logic [1:0]               buttons,
	output logic                     forced_scandoubler,
	output logic                     direct_video,
	output logic [`HPS_JOY_W-1:0]    joystick_0,
	output logic [`HPS_JOY_W-1:0]    joystick_1,
	output logic [`HPS_STATUS_W-1:0] status,
	input  logic [`HPS_STATUS_W-1:0] status_in,
	input  logic                     status_set,
	output logic [10:0]              ps2_key
);

	localparam int strlen = $bits(conf_str) / 8;
	localparam int widx_w = $clog2(`HPS_STATUS_WORDS);

	hps_cmd_pkg::uio_cmd_e cmd;
	logic [`HPS_CNT_W-1:0] cnt;
	logic [`HPS_WORD_W-1:0] cfg;
	logic [`HPS_STATUS_W-1:0] status_req;
	logic [3:0] set_cnt;
	logic status_set_d;
	logic set_rise;
	logic [7:0] conf_byte;
	logic [widx_w-1:0] widx;
	logic in_status;

	assign buttons = cfg[1:0];
	assign forced_scandoubler = cfg[`HPS_CFG_SCANDBL];
	assign direct_video = cfg[`HPS_CFG_DIRECT];

	// data word n maps to status word n-1
	assign widx = widx_w'(cnt - 1'b1);
	assign in_status = (cnt != 0) && (cnt <= `HPS_STATUS_WORDS);

	// character n of the string, leftmost first
	always_comb begin
		conf_byte = 8'h00;
		if (cnt != 0 && int'(cnt) <= strlen)
			conf_byte = conf_str[(strlen - int'(cnt)) * 8 +: 8];
	end

	////////////////////
	// status-set request from the core

	assign set_rise = status_set && !status_set_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status_set_d <= 1'b0;
			set_cnt <= '0;
		end else begin
			status_set_d <= status_set;
			if (set_rise)
				set_cnt <= set_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (set_rise)
			status_req <= status_in;
	end

	////////////////////
	// command framing and register writes

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd <= hps_cmd_pkg::cmd_none;
			cnt <= '0;
			uio_dout <= '0;
			cfg <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status <= '0;
		end else if (!io_enable) begin
			cmd <= hps_cmd_pkg::cmd_none;
			cnt <= '0;
			uio_dout <= '0;
		end else if (io_strobe) begin
			uio_dout <= '0;
			if (cnt != {`HPS_CNT_W{1'b1}})
				cnt <= cnt + 1'b1;
			if (cnt == 0) begin
				cmd <= hps_cmd_pkg::uio_cmd_e'(io_din);
				// reply to the opcode itself
				if (io_din == hps_cmd_pkg::cmd_status_set)
					uio_dout <= {8'h00, `HPS_SET_TAG, set_cnt};
			end else begin
				case (cmd)
					hps_cmd_pkg::cmd_cfg: cfg <= io_din;
					hps_cmd_pkg::cmd_joy0: begin
						if (cnt == 1)
							joystick_0[`HPS_WORD_W-1:0] <= io_din;
						else
							joystick_0[`HPS_JOY_W-1:`HPS_WORD_W] <= io_din;
					end
					hps_cmd_pkg::cmd_joy1: begin
						if (cnt == 1)
							joystick_1[`HPS_WORD_W-1:0] <= io_din;
						else
							joystick_1[`HPS_JOY_W-1:`HPS_WORD_W] <= io_din;
					end
					hps_cmd_pkg::cmd_status: begin
						if (in_status)
							status[widx * `HPS_WORD_W +: `HPS_WORD_W] <= io_din;
					end
					hps_cmd_pkg::cmd_status_set: begin
						if (in_status)
							uio_dout <= status_req[widx * `HPS_WORD_W +: `HPS_WORD_W];
					end
					hps_cmd_pkg::cmd_conf_str: uio_dout <= {8'h00, conf_byte};
					default: ;
				endcase
			end
		end
	end

	ps2_key_decoder u_key (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_strobe (io_strobe),
		.io_enable (io_enable),
		.io_din    (io_din),
		.cmd       (cmd),
		.ps2_key   (ps2_key)
	);

	// long frames park the counter, so word 0 is seen once per frame
	a_cnt_no_wrap: assert property (@(posedge clk_sys) disable iff (reset)
		(io_enable && cnt != 0) |=> (cnt != 0));

endmodule

/* hps_cmd_pkg.sv */
////////////////////
// opcodes of the user command channel
////////////////////
`include "hps_defs.svh"

package hps_cmd_pkg;

	// first word of an io_enable frame
	typedef enum logic [`HPS_WORD_W-1:0] {
		cmd_none       = 16'h0000,
		cmd_cfg        = 16'h0001,
		cmd_joy0       = 16'h0002,
		cmd_joy1       = 16'h0003,
		cmd_kbd        = 16'h0005,
		// readbacks
		cmd_conf_str   = 16'h0014,
		cmd_status     = 16'h001E,
		cmd_status_set = 16'h0029
	} uio_cmd_e;

endpackage

/* hps_defs.svh */
////////////////////
// widths and fixed field positions of the host command port
// include wherever one of these is needed
////////////////////
`ifndef HPS_DEFS_SVH
`define HPS_DEFS_SVH

// host link words
`define HPS_WORD_W        16
`define HPS_CNT_W         8

// file channel
`define HPS_DATA_W        8
`define HPS_ADDR_W        27
`define HPS_UPLOAD_MARK   8'hAA

// user registers
`define HPS_JOY_W         32
`define HPS_STATUS_W      128
`define HPS_STATUS_WORDS  8
`define HPS_CFG_SCANDBL   4
`define HPS_CFG_DIRECT    10
`define HPS_SKIP_MARK     8'hFF
`define HPS_SET_TAG       4'hA

`endif

/* hps_file_pkg.sv */
////////////////////
// opcodes and transfer modes of the file channel
////////////////////
package hps_file_pkg;

	// first word of an fp_enable frame, low byte only
	typedef enum logic [7:0] {
		file_tx     = 8'h53,
		file_tx_dat = 8'h54,
		file_index  = 8'h55
	} fio_cmd_e;

	// direction of the running transfer
	typedef enum logic [1:0] {
		xfer_idle     = 2'd0,
		xfer_download = 2'd1,
		xfer_upload   = 2'd2
	} xfer_mode_e;

endpackage

/* hps_io.f */
+incdir+.
hps_cmd_pkg.sv
hps_file_pkg.sv
ps2_key_decoder.sv
hps_cmd_decoder.sv
file_loader.sv
hps_io.sv
tb_hps_io.sv

/* hps_io.sv */
////////////////////
// host command port, joins the user and file channels
////////////////////
`timescale 1ns/1ns
`include "hps_defs.svh"

module hps_io #(
	parameter conf_str = "CORE;"
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     io_strobe,
	input  logic                     io_enable,
	input  logic                     fp_enable,
	input  logic [`HPS_WORD_W-1:0]   io_din,
	output logic [`HPS_WORD_W-1:0]   io_dout,
	output logic [1:0]               buttons,
	output logic                     forced_scandoubler,
	output logic                     direct_video,
	output logic [`HPS_JOY_W-1:0]    joystick_0,
	output logic [`HPS_JOY_W-1:0]    joystick_1,
	output logic [`HPS_STATUS_W-1:0] status,
	input  logic [`HPS_STATUS_W-1:0] status_in,
	input  logic                     status_set,
	output logic [10:0]              ps2_key,
	output logic                     ioctl_download,
	output logic                     ioctl_upload,
	output logic                     ioctl_wr,
	output logic                     ioctl_rd,
	output logic [`HPS_WORD_W-1:0]   ioctl_index,
	output logic [`HPS_ADDR_W-1:0]   ioctl_addr,
	output logic [`HPS_DATA_W-1:0]   ioctl_dout,
	input  logic [`HPS_DATA_W-1:0]   ioctl_din
);

	logic [`HPS_WORD_W-1:0] uio_dout;
	logic [`HPS_WORD_W-1:0] fp_dout;

	// file channel owns the return word while its frame is open
	assign io_dout = fp_enable ? fp_dout : uio_dout;

	hps_cmd_decoder #(
		.conf_str (conf_str)
	) u_cmd (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.io_din             (io_din),
		.uio_dout           (uio_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.ps2_key            (ps2_key)
	);

	file_loader u_file (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.io_strobe      (io_strobe),
		.fp_enable      (fp_enable),
		.io_din         (io_din),
		.fp_dout        (fp_dout),
		.ioctl_download (ioctl_download),
		.ioctl_upload   (ioctl_upload),
		.ioctl_wr       (ioctl_wr),
		.ioctl_rd       (ioctl_rd),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_din      (ioctl_din)
	);

endmodule

/* ps2_key_decoder.sv */
////////////////////
// turns the scan bytes of one keyboard command into a key event
////////////////////
`timescale 1ns/1ns
`include "hps_defs.svh"

module ps2_key_decoder (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   io_strobe,
	input  logic                   io_enable,
	input  logic [`HPS_WORD_W-1:0] io_din,
	input  hps_cmd_pkg::uio_cmd_e  cmd,
	output logic [10:0]            ps2_key
);

	localparam logic [7:0] break_code = 8'hF0;
	localparam logic [7:0] ext_code = 8'hE0;

	logic [31:0] key_raw;
	logic skip;
	logic enable_d;
	logic pressed;
	logic extended;
	logic key_done;

	// E0 sits before the key byte, or before F0 on a release
	assign pressed = key_raw[15:8] != break_code;
	assign extended = pressed ? (key_raw[15:8] == ext_code) : (key_raw[23:16] == ext_code);
	assign key_done = enable_d && !io_enable && cmd == hps_cmd_pkg::cmd_kbd && !skip;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			enable_d <= 1'b0;
			skip <= 1'b0;
			ps2_key <= '0;
		end else begin
			enable_d <= io_enable;
			if (key_done)
				ps2_key <= {~ps2_key[10], pressed, extended, key_raw[7:0]};
			if (!io_enable)
				skip <= 1'b0;
			else if (io_strobe && cmd == hps_cmd_pkg::cmd_kbd && io_din[15:8] == `HPS_SKIP_MARK)
				skip <= 1'b1;
		end
	end

	// scan byte history, newest in the low byte
	always_ff @(posedge clk_sys) begin
		if (io_enable && io_strobe) begin
			if (cmd == hps_cmd_pkg::cmd_none) begin
				if (io_din == hps_cmd_pkg::cmd_kbd)
					key_raw <= '0;
			end else if (cmd == hps_cmd_pkg::cmd_kbd && io_din[15:8] != `HPS_SKIP_MARK && !skip) begin
				key_raw <= {key_raw[23:0], io_din[7:0]};
			end
		end
	end

	a_key_on_fall: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(ps2_key) |-> ($past(io_enable, 2) && !$past(io_enable)));

endmodule

/* tb_hps_io.sv */
////////////////////
// testbench for the host command port, random frames checked against a model
// compile with the file list, top module tb_hps_io
////////////////////
`timescale 1ns/1ns
`include "hps_defs.svh"

module tb_hps_io;

	localparam int n_cfg = 6;
	localparam int n_stat = 4;
	localparam int n_key = 12;
	localparam int n_dl = 12;
	localparam int n_up = 10;
	// frames issued over the whole run
	localparam int n_frames = 3 * n_cfg + 2 * n_stat + 1 + n_key + 7;

	logic clk_sys = 1'b0;
	logic reset;
	logic io_strobe;
	logic io_enable;
	logic fp_enable;
	logic [`HPS_WORD_W-1:0] io_din;
	logic [`HPS_WORD_W-1:0] io_dout;
	logic [1:0] buttons;
	logic forced_scandoubler;
	logic direct_video;
	logic [`HPS_JOY_W-1:0] joystick_0;
	logic [`HPS_JOY_W-1:0] joystick_1;
	logic [`HPS_STATUS_W-1:0] status;
	logic [`HPS_STATUS_W-1:0] status_in;
	logic status_set;
	logic [10:0] ps2_key;
	logic ioctl_download;
	logic ioctl_upload;
	logic ioctl_wr;
	logic ioctl_rd;
	logic [`HPS_WORD_W-1:0] ioctl_index;
	logic [`HPS_ADDR_W-1:0] ioctl_addr;
	logic [`HPS_DATA_W-1:0] ioctl_dout;
	logic [`HPS_DATA_W-1:0] ioctl_din;

	logic [15:0] lfsr = 16'd72;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	// model state carried between tests
	logic [3:0] exp_set_cnt = 4'd0;
	logic [10:0] exp_key = 11'd0;
	string conf_text = "CORE;O1,Scan;";
	// core side view of the file channel
	logic [`HPS_ADDR_W-1:0] addr_seen = '0;
	logic [`HPS_ADDR_W-1:0] wr_addr[$];
	logic [`HPS_DATA_W-1:0] wr_data[$];
	int rd_count = 0;

	hps_io #(
		.conf_str ("CORE;O1,Scan;")
	) uut (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.io_strobe          (io_strobe),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_din             (io_din),
		.io_dout            (io_dout),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_upload       (ioctl_upload),
		.ioctl_wr           (ioctl_wr),
		.ioctl_rd           (ioctl_rd),
		.ioctl_index        (ioctl_index),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_din          (ioctl_din)
	);

	always #2 clk_sys = ~clk_sys;

	////////////////////
	// random numbers and core side models

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	function automatic logic [127:0] rand_bits(input int n);
		logic [127:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[126:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
		return r;
	endfunction

	// upload data the core returns for an address
	function automatic logic [`HPS_DATA_W-1:0] din_for(input logic [`HPS_ADDR_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {5'b0, a[26:24]} ^ 8'h3C;
	endfunction

	function automatic logic [`HPS_WORD_W-1:0] cfg_view(input logic [1:0] b, input logic sd,
		input logic dv);
		logic [`HPS_WORD_W-1:0] w;
		w = '0;
		w[1:0] = b;
		w[`HPS_CFG_SCANDBL] = sd;
		w[`HPS_CFG_DIRECT] = dv;
		return w;
	endfunction

	function automatic logic [`HPS_WORD_W-1:0] mode_word();
		return {14'b0, ioctl_upload, ioctl_download};
	endfunction

	always @(negedge clk_sys) begin
		addr_seen = ioctl_addr;
		if (ioctl_wr) begin
			wr_addr.push_back(ioctl_addr);
			wr_data.push_back(ioctl_dout);
		end
		if (ioctl_rd)
			rd_count++;
	end

	always @(posedge clk_sys)
		ioctl_din <= din_for(addr_seen);

	////////////////////
	// compare tasks

	task automatic compare_word(input string name, input logic [`HPS_WORD_W-1:0] exp,
		input logic [`HPS_WORD_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compare_joy(input string name, input logic [`HPS_JOY_W-1:0] exp,
		input logic [`HPS_JOY_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compare_status(input string name, input logic [`HPS_STATUS_W-1:0] exp,
		input logic [`HPS_STATUS_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compare_key(input string name, input logic [10:0] exp,
		input logic [10:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compare_addr(input string name, input logic [`HPS_ADDR_W-1:0] exp,
		input logic [`HPS_ADDR_W-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors != err_before) begin
			tests_failed++;
			$display("test %s: %0d mismatches", name, errors - err_before);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	////////////////////
	// host link driver

	task automatic open_frame(input logic file_side);
		@(posedge clk_sys);
		if (file_side)
			fp_enable <= 1'b1;
		else
			io_enable <= 1'b1;
	endtask

	// drop the enable and let the channel settle
	task automatic close_frame();
		@(posedge clk_sys);
		io_enable <= 1'b0;
		fp_enable <= 1'b0;
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// one strobed word, reply read a cycle later, then a random gap
	task automatic send_word(input logic [`HPS_WORD_W-1:0] w,
		output logic [`HPS_WORD_W-1:0] reply);
		int gap;
		gap = int'(rand_bits(3));
		@(posedge clk_sys);
		io_strobe <= 1'b1;
		io_din <= w;
		@(posedge clk_sys);
		io_strobe <= 1'b0;
		@(negedge clk_sys);
		reply = io_dout;
		repeat (gap) @(posedge clk_sys);
	endtask

	task automatic send_file_cmd(input hps_file_pkg::fio_cmd_e op, input logic [15:0] w);
		logic [`HPS_WORD_W-1:0] r;
		open_frame(1'b1);
		send_word({8'h00, op}, r);
		send_word(w, r);
		close_frame();
	endtask

	task automatic write_joystick(input hps_cmd_pkg::uio_cmd_e op,
		inout logic [`HPS_JOY_W-1:0] joy);
		logic [`HPS_WORD_W-1:0] r;
		logic [`HPS_JOY_W-1:0] val;
		logic two;
		val = 32'(rand_bits(32));
		two = 1'(rand_bits(1));
		open_frame(1'b0);
		send_word(op, r);
		send_word(val[15:0], r);
		joy[15:0] = val[15:0];
		if (two) begin
			send_word(val[31:16], r);
			joy[31:16] = val[31:16];
		end
		close_frame();
	endtask

	////////////////////
	// tests

	task automatic test_config();
		int e0;
		logic [`HPS_WORD_W-1:0] r;
		logic [`HPS_WORD_W-1:0] cfg;
		logic [`HPS_JOY_W-1:0] joy0;
		logic [`HPS_JOY_W-1:0] joy1;
		e0 = errors;
		joy0 = '0;
		joy1 = '0;
		compare_word("io_dout after reset", '0, io_dout);
		compare_key("ps2_key after reset", '0, ps2_key);
		compare_word("file mode after reset", '0, mode_word());
		for (int i = 0; i < n_cfg; i++) begin
			cfg = 16'(rand_bits(16));
			open_frame(1'b0);
			send_word(hps_cmd_pkg::cmd_cfg, r);
			send_word(cfg, r);
			close_frame();
			write_joystick(hps_cmd_pkg::cmd_joy0, joy0);
			write_joystick(hps_cmd_pkg::cmd_joy1, joy1);
			compare_word("config bits",
				cfg_view(cfg[1:0], cfg[`HPS_CFG_SCANDBL], cfg[`HPS_CFG_DIRECT]),
				cfg_view(buttons, forced_scandoubler, direct_video));
			compare_joy("joystick_0", joy0, joystick_0);
			compare_joy("joystick_1", joy1, joystick_1);
		end
		report_test("config and joystick", e0);
	endtask

	task automatic test_status();
		int e0;
		logic [`HPS_WORD_W-1:0] r;
		logic [`HPS_STATUS_W-1:0] val;
		logic [`HPS_STATUS_W-1:0] req;
		e0 = errors;
		for (int i = 0; i < n_stat; i++) begin
			val = rand_bits(128);
			open_frame(1'b0);
			send_word(hps_cmd_pkg::cmd_status, r);
			for (int w = 0; w < `HPS_STATUS_WORDS; w++)
				send_word(val[w * 16 +: 16], r);
			close_frame();
			compare_status("status", val, status);
			// request from the core, rising edge of the level
			req = rand_bits(128);
			@(posedge clk_sys);
			status_in <= req;
			status_set <= 1'b1;
			@(posedge clk_sys);
			status_set <= 1'b0;
			exp_set_cnt = exp_set_cnt + 4'd1;
			open_frame(1'b0);
			send_word(hps_cmd_pkg::cmd_status_set, r);
			compare_word("status_set tag", {8'h00, `HPS_SET_TAG, exp_set_cnt}, r);
			for (int w = 0; w < `HPS_STATUS_WORDS; w++) begin
				send_word('0, r);
				compare_word("status_set word", req[w * 16 +: 16], r);
			end
			close_frame();
		end
		report_test("status", e0);
	endtask

	task automatic test_conf_string();
		int e0;
		logic [`HPS_WORD_W-1:0] r;
		logic [`HPS_WORD_W-1:0] exp;
		e0 = errors;
		open_frame(1'b0);
		send_word(hps_cmd_pkg::cmd_conf_str, r);
		for (int n = 1; n <= conf_text.len() + 2; n++) begin
			send_word('0, r);
			exp = (n <= conf_text.len()) ? {8'h00, conf_text[n - 1]} : '0;
			compare_word("config string char", exp, r);
		end
		close_frame();
		compare_word("io_dout idle", '0, io_dout);
		report_test("config string", e0);
	endtask

	task automatic test_keys();
		int e0;
		int pos;
		logic skip;
		logic [7:0] kb[$];
		logic [7:0] prev;
		logic [7:0] prev2;
		logic pressed;
		logic [`HPS_WORD_W-1:0] r;
		e0 = errors;
		for (int k = 0; k < n_key; k++) begin
			skip = (k % 4 == 3);
			kb.delete();
			if (rand_bits(1))
				kb.push_back(8'hE0);
			if (rand_bits(1))
				kb.push_back(8'hF0);
			kb.push_back(8'(rand_bits(8)));
			pos = int'(rand_bits(2)) % (kb.size() + 1);
			open_frame(1'b0);
			send_word(hps_cmd_pkg::cmd_kbd, r);
			for (int j = 0; j <= kb.size(); j++) begin
				if (skip && j == pos)
					send_word({`HPS_SKIP_MARK, 8'(rand_bits(8))}, r);
				if (j < kb.size())
					send_word({8'h00, kb[j]}, r);
			end
			close_frame();
			if (!skip) begin
				prev = (kb.size() > 1) ? kb[kb.size() - 2] : 8'h00;
				prev2 = (kb.size() > 2) ? kb[kb.size() - 3] : 8'h00;
				pressed = prev != 8'hF0;
				exp_key = {~exp_key[10], pressed,
					pressed ? (prev == 8'hE0) : (prev2 == 8'hE0), kb[kb.size() - 1]};
			end
			compare_key("ps2_key", exp_key, ps2_key);
		end
		report_test("keyboard", e0);
	endtask

	task automatic test_download();
		int e0;
		logic [`HPS_WORD_W-1:0] r;
		logic [`HPS_WORD_W-1:0] idx;
		logic [7:0] start;
		logic [7:0] bytes[$];
		e0 = errors;
		idx = 16'(rand_bits(16));
		send_file_cmd(hps_file_pkg::file_index, idx);
		compare_word("ioctl_index", idx, ioctl_index);
		start = 8'(rand_bits(8));
		if (start == 8'h00 || start == `HPS_UPLOAD_MARK)
			start = 8'h01;
		send_file_cmd(hps_file_pkg::file_tx, {8'h00, start});
		compare_word("download mode", 16'(hps_file_pkg::xfer_download), mode_word());
		wr_addr.delete();
		wr_data.delete();
		open_frame(1'b1);
		send_word({8'h00, hps_file_pkg::file_tx_dat}, r);
		for (int i = 0; i < n_dl; i++) begin
			bytes.push_back(8'(rand_bits(8)));
			send_word({8'h00, bytes[i]}, r);
		end
		close_frame();
		send_file_cmd(hps_file_pkg::file_tx, '0);
		compare_word("mode after download", 16'(hps_file_pkg::xfer_idle), mode_word());
		compare_word("write pulses", 16'(n_dl), 16'(wr_addr.size()));
		for (int i = 0; i < n_dl && i < wr_addr.size(); i++) begin
			compare_addr("write address", 27'(i), wr_addr[i]);
			compare_word("write data", {8'h00, bytes[i]}, {8'h00, wr_data[i]});
		end
		compare_word("ioctl_index held", idx, ioctl_index);
		report_test("download", e0);
	endtask

	task automatic test_upload();
		int e0;
		logic [`HPS_WORD_W-1:0] r;
		e0 = errors;
		rd_count = 0;
		send_file_cmd(hps_file_pkg::file_tx, {8'h00, `HPS_UPLOAD_MARK});
		compare_word("upload mode", 16'(hps_file_pkg::xfer_upload), mode_word());
		compare_addr("upload start address", '0, ioctl_addr);
		open_frame(1'b1);
		send_word({8'h00, hps_file_pkg::file_tx_dat}, r);
		for (int i = 0; i < n_up; i++) begin
			send_word('0, r);
			compare_word("upload data", {8'h00, din_for(27'(i))}, r);
		end
		close_frame();
		compare_addr("upload end address", 27'(n_up), ioctl_addr);
		send_file_cmd(hps_file_pkg::file_tx, '0);
		compare_word("mode after upload", 16'(hps_file_pkg::xfer_idle), mode_word());
		compare_word("read pulses", 16'(n_up + 1), 16'(rd_count));
		report_test("upload", e0);
	endtask

	////////////////////
	// run and report

	initial begin
		reset = 1'b1;
		io_strobe = 1'b0;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_din = '0;
		status_in = '0;
		status_set = 1'b0;
		ioctl_din = '0;
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);
		test_config();
		test_status();
		test_conf_string();
		test_keys();
		test_download();
		test_upload();
		$display("tests %0d, failing %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// budget of 200 cycles per frame
	initial begin
		repeat (200 * n_frames + 20) @(posedge clk_sys);
		$display("watchdog: the run did not finish within its cycle budget");
		$display("Simulation failed");
		$finish;
	end

endmodule
